// File: sfm_pkg.sv
package sfm_pkg;

    // Datapath widths
    localparam int unsigned ACC_W = 32;
    localparam int unsigned ADD_W = 16;
    localparam int unsigned MUL_W = 16;

    // Enough for factor queues up to 4 deep
    localparam int unsigned TAG_W = 3;

    // Defaults handed down by the top level
    localparam int unsigned DEF_NUM_STAGES = 3;
    localparam int unsigned DEF_ADD_DEPTH  = 4;
    localparam int unsigned DEF_FACT_DEPTH = 4;

    typedef logic [ACC_W-1:0] acc_t;   // Partial sums and result
    typedef logic [ADD_W-1:0] add_t;   // Exponent terms
    typedef logic [MUL_W-1:0] mul_t;   // Rescale factors

    // Number of factors accepted so far, wraps
    typedef logic [TAG_W-1:0] tag_t;

    typedef enum logic [2:0] {
        IDLE,
        COMPUTING,
        FINISHING,
        REDUCTION,
        FINISHED
    } acc_state_e;

endpackage

// File: sfm_fifo.sv
`timescale 1ns/10ps

module sfm_fifo #(
    parameter int unsigned DEPTH = 4,
    parameter int unsigned WIDTH = 8
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    input  logic             push_i,
    input  logic             pop_i,
    input  logic [WIDTH-1:0] data_i,
    output logic [WIDTH-1:0] data_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i & ~full_o;   // Overflow is dropped
    assign do_pop  = pop_i & ~empty_o;

    assign data_o = mem_q[rd_ptr_q];     // Head, registered storage only

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (!do_push && do_pop) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

// File: sfm_mac_pipe.sv
`timescale 1ns/10ps

module sfm_mac_pipe import sfm_pkg::*; #(
    parameter int unsigned NUM_STAGES = DEF_NUM_STAGES
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  acc_t sum_i,
    input  acc_t factor_i,
    input  acc_t addend_i,
    output acc_t result_o
);

    // First stage
    acc_t prod_q;
    acc_t addend_q;

    // Index 1 is the adder output, the rest only delay
    acc_t stage_q [NUM_STAGES-1:1];

    // Product wraps modulo 2^32
    always_ff @(posedge clk_i or negedge rst_ni) begin : mul_stage
        if (!rst_ni) begin
            prod_q   <= '0;
            addend_q <= '0;
        end else if (flush_i) begin
            prod_q   <= '0;
            addend_q <= '0;
        end else begin
            prod_q   <= sum_i * factor_i;
            addend_q <= addend_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : add_stage
        if (!rst_ni) begin
            stage_q[1] <= '0;
        end else if (flush_i) begin
            stage_q[1] <= '0;
        end else begin
            stage_q[1] <= prod_q + addend_q;
        end
    end

    // Pads the loop out to NUM_STAGES slots
    for (genvar i = 2; i < NUM_STAGES; i++) begin : gen_delay
        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                stage_q[i] <= '0;
            end else if (flush_i) begin
                stage_q[i] <= '0;
            end else begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign result_o = stage_q[NUM_STAGES-1];

endmodule

// File: sfm_accumulator.sv
`timescale 1ns/10ps

module sfm_accumulator import sfm_pkg::*; #(
    parameter int unsigned NUM_STAGES = DEF_NUM_STAGES,
    parameter int unsigned ADD_DEPTH  = DEF_ADD_DEPTH,
    parameter int unsigned FACT_DEPTH = DEF_FACT_DEPTH
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic clear_i,
    input  logic add_valid_i,
    input  add_t add_i,
    input  logic mul_valid_i,
    input  mul_t mul_i,
    input  logic finish_i,
    output logic ready_o,
    output logic valid_o,
    output acc_t acc_o
);

    localparam int unsigned ADD_FW  = ADD_W + TAG_W;
    localparam int unsigned FACT_FW = MUL_W + TAG_W;
    localparam int unsigned CNT_W   = $clog2(NUM_STAGES);

    acc_state_e state_q;
    acc_state_e state_d;

    tag_t             tag_cnt_q;
    logic             apply_q;
    logic [CNT_W-1:0] apply_cnt_q;
    logic [CNT_W-1:0] red_cnt_q;
    acc_t             result_q;

    // Queue signals
    logic               add_push;
    logic               add_pop;
    logic               add_full;
    logic               add_empty;
    logic [ADD_FW-1:0]  add_wdata;
    logic [ADD_FW-1:0]  add_rdata;
    logic               fact_push;
    logic               fact_pop;
    logic               fact_full;
    logic               fact_empty;
    logic [FACT_FW-1:0] fact_wdata;
    logic [FACT_FW-1:0] fact_rdata;

    add_t add_head;
    tag_t add_head_tag;
    mul_t fact_head;
    tag_t fact_head_tag;

    logic accept;
    logic start;
    logic reducing;
    logic add_qual;
    logic add_go;
    logic apply_start;
    logic apply_now;
    logic apply_last;
    logic red_last;
    logic pipe_flush;

    acc_t pipe_factor;
    acc_t pipe_addend;
    acc_t pipe_res;

    assign reducing = (state_q == REDUCTION);

    assign ready_o = ~add_full & ~fact_full & (state_q != FINISHING) & ~reducing;
    assign valid_o = (state_q == FINISHED);
    assign acc_o   = result_q;

    assign add_push  = add_valid_i & ready_o;
    assign fact_push = mul_valid_i & ready_o;
    assign accept    = add_push | fact_push;
    assign start     = accept & ((state_q == IDLE) | (state_q == FINISHED));

    // Slots restart from zero on a new run
    assign pipe_flush = clear_i | start;

    // Same-cycle addend shares the tag, so it counts as earlier
    assign add_wdata  = {add_i, tag_cnt_q};
    assign fact_wdata = {mul_i, tag_cnt_q};

    assign {add_head, add_head_tag}   = add_rdata;
    assign {fact_head, fact_head_tag} = fact_rdata;

    // Pending tags stay within one queue depth, so plain equality is enough
    assign add_qual    = ~add_empty & (fact_empty | (add_head_tag == fact_head_tag));
    assign add_go      = add_qual & ~apply_q;
    assign apply_start = ~apply_q & ~fact_empty & ~add_qual;
    assign apply_now   = apply_q | apply_start;
    assign apply_last  = apply_now & (apply_cnt_q == CNT_W'(NUM_STAGES - 1));
    assign red_last    = reducing & (red_cnt_q == CNT_W'(NUM_STAGES - 1));

    assign add_pop  = add_go;
    assign fact_pop = apply_last;   // Every slot has seen the factor

    sfm_fifo #(
        .DEPTH (ADD_DEPTH),
        .WIDTH (ADD_FW)
    ) addend_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (clear_i),
        .push_i  (add_push),
        .pop_i   (add_pop),
        .data_i  (add_wdata),
        .data_o  (add_rdata),
        .full_o  (add_full),
        .empty_o (add_empty)
    );

    sfm_fifo #(
        .DEPTH (FACT_DEPTH),
        .WIDTH (FACT_FW)
    ) factor_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (clear_i),
        .push_i  (fact_push),
        .pop_i   (fact_pop),
        .data_i  (fact_wdata),
        .data_o  (fact_rdata),
        .full_o  (fact_full),
        .empty_o (fact_empty)
    );

    always_comb begin : operand_select
        pipe_factor = acc_t'(1);
        pipe_addend = '0;
        if (reducing) begin
            pipe_factor = '0;                   // Feed zeros back while draining
        end else if (apply_now) begin
            pipe_factor = acc_t'(fact_head);
        end else if (add_go) begin
            pipe_addend = acc_t'(add_head);
        end
    end

    sfm_mac_pipe #(
        .NUM_STAGES (NUM_STAGES)
    ) mac_pipe (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .flush_i  (pipe_flush),
        .sum_i    (pipe_res),
        .factor_i (pipe_factor),
        .addend_i (pipe_addend),
        .result_o (pipe_res)
    );

    always_comb begin : fsm_next
        state_d = state_q;
        unique case (state_q)
            IDLE:      if (accept) state_d = COMPUTING;
            COMPUTING: if (finish_i) state_d = FINISHING;
            FINISHING: begin
                if (add_empty && fact_empty && !apply_q) begin
                    state_d = REDUCTION;
                end
            end
            REDUCTION: if (red_last) state_d = FINISHED;
            FINISHED:  if (accept) state_d = COMPUTING;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
        if (!rst_ni) begin
            state_q <= IDLE;
        end else if (clear_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : counters
        if (!rst_ni) begin
            tag_cnt_q   <= '0;
            apply_q     <= 1'b0;
            apply_cnt_q <= '0;
            red_cnt_q   <= '0;
        end else if (clear_i) begin
            tag_cnt_q   <= '0;
            apply_q     <= 1'b0;
            apply_cnt_q <= '0;
            red_cnt_q   <= '0;
        end else begin
            if (fact_push) begin
                tag_cnt_q <= tag_cnt_q + 1'b1;
            end
            apply_q <= apply_now & ~apply_last;
            if (apply_last) begin
                apply_cnt_q <= '0;
            end else if (apply_now) begin
                apply_cnt_q <= apply_cnt_q + 1'b1;
            end
            if (red_last) begin
                red_cnt_q <= '0;
            end else if (reducing) begin
                red_cnt_q <= red_cnt_q + 1'b1;
            end
        end
    end

    // Holds until clear or the next run
    always_ff @(posedge clk_i or negedge rst_ni) begin : result_reg
        if (!rst_ni) begin
            result_q <= '0;
        end else if (clear_i || start) begin
            result_q <= '0;
        end else if (reducing) begin
            result_q <= result_q + pipe_res;
        end
    end

endmodule

// File: sfm_acc_top.sv
`timescale 1ns/10ps

module sfm_acc_top import sfm_pkg::*; #(
    parameter int unsigned NUM_STAGES = DEF_NUM_STAGES,
    parameter int unsigned ADD_DEPTH  = DEF_ADD_DEPTH,
    parameter int unsigned FACT_DEPTH = DEF_FACT_DEPTH
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic clear_i,
    input  logic add_valid_i,
    input  add_t add_i,
    input  logic mul_valid_i,
    input  mul_t mul_i,
    input  logic finish_i,
    output logic ready_o,
    output logic valid_o,
    output acc_t acc_o
);

    sfm_accumulator #(
        .NUM_STAGES (NUM_STAGES),
        .ADD_DEPTH  (ADD_DEPTH),
        .FACT_DEPTH (FACT_DEPTH)
    ) u_acc (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (clear_i),
        .add_valid_i (add_valid_i),
        .add_i       (add_i),
        .mul_valid_i (mul_valid_i),
        .mul_i       (mul_i),
        .finish_i    (finish_i),
        .ready_o     (ready_o),
        .valid_o     (valid_o),
        .acc_o       (acc_o)
    );

endmodule

// File: sfm_acc_sva.sv
`timescale 1ns/10ps

module sfm_acc_sva import sfm_pkg::*; #(
    parameter int unsigned NUM_STAGES = DEF_NUM_STAGES,
    parameter int unsigned ADD_DEPTH  = DEF_ADD_DEPTH,
    parameter int unsigned FACT_DEPTH = DEF_FACT_DEPTH
) (
    input logic clk_i,
    input logic rst_ni,
    input logic clear_i,
    input logic finish_i,
    input logic ready_i,
    input logic valid_i,
    input acc_t acc_i
);

    // Full drain plus reduction and the state hops around them
    localparam int unsigned MAX_LAT = ADD_DEPTH + (FACT_DEPTH + 1) * NUM_STAGES + 8;

    int unsigned fail_cnt = 0;
    logic        awaiting_q;   // Between finish and the result
    int unsigned wait_cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            awaiting_q <= 1'b0;
            wait_cnt_q <= 0;
        end else if (clear_i || valid_i) begin
            awaiting_q <= 1'b0;
            wait_cnt_q <= 0;
        end else if (finish_i && !awaiting_q) begin
            awaiting_q <= 1'b1;
            wait_cnt_q <= 0;
        end else if (awaiting_q) begin
            wait_cnt_q <= wait_cnt_q + 1;
        end
    end

    valid_low_after_reset: assert property (@(posedge clk_i) !rst_ni |=> !valid_i)
        else begin
            $error("valid_o high right out of reset");
            fail_cnt++;
        end

    ready_low_while_finishing: assert property (@(posedge clk_i)
        disable iff (!rst_ni || clear_i) awaiting_q && !valid_i |-> !ready_i)
        else begin
            $error("ready_o high between finish_i and valid_o");
            fail_cnt++;
        end

    result_stable: assert property (@(posedge clk_i)
        disable iff (!rst_ni) valid_i && $past(valid_i) |-> $stable(acc_i))
        else begin
            $error("acc_o changed while valid_o stayed high");
            fail_cnt++;
        end

    result_in_time: assert property (@(posedge clk_i)
        disable iff (!rst_ni || clear_i) awaiting_q |-> wait_cnt_q < MAX_LAT)
        else begin
            $error("valid_o late after finish_i");
            fail_cnt++;
        end

endmodule

bind sfm_acc_top sfm_acc_sva #(
    .NUM_STAGES (NUM_STAGES),
    .ADD_DEPTH  (ADD_DEPTH),
    .FACT_DEPTH (FACT_DEPTH)
) sva_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .finish_i (finish_i),
    .ready_i  (ready_o),
    .valid_i  (valid_o),
    .acc_i    (acc_o)
);

// File: tb_sfm_acc.sv
`timescale 1ns/10ps

module tb_sfm_acc import sfm_pkg::*; ();

    localparam int unsigned CLK_PERIOD  = 100;
    localparam int unsigned DRIVE_DLY   = 10;
    localparam int unsigned MAX_CYCLES  = 4000;
    localparam int unsigned NUM_RESULTS = 5;

    logic clk;
    logic rst_n;
    logic clear;
    logic add_valid;
    add_t add_data;
    logic mul_valid;
    mul_t mul_data;
    logic finish;
    logic ready;
    logic valid;
    acc_t acc;

    integer      seed;
    acc_t        model_sum;      // Expected result of the current run
    logic        valid_seen;
    int unsigned results_seen;
    int unsigned held_off;       // Offers refused by back-pressure
    int unsigned cycle_cnt;

    sfm_acc_top dut_i (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .clear_i     (clear),
        .add_valid_i (add_valid),
        .add_i       (add_data),
        .mul_valid_i (mul_valid),
        .mul_i       (mul_data),
        .finish_i    (finish),
        .ready_o     (ready),
        .valid_o     (valid),
        .acc_o       (acc)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped on the first error");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    // Offers inputs regardless of ready, the model only counts accepted ones
    task automatic drive_random(input int unsigned n, input int unsigned add_pct,
                                input int unsigned mul_pct);
        for (int unsigned i = 0; i < n; i++) begin
            add_valid = (($random(seed) & 32'h7fff_ffff) % 100) < add_pct;
            mul_valid = (($random(seed) & 32'h7fff_ffff) % 100) < mul_pct;
            add_data  = add_t'($random(seed));
            mul_data  = mul_t'($random(seed)) | mul_t'(1);   // Odd factors keep the sum alive
            next_cycle();
        end
        add_valid = 1'b0;
        mul_valid = 1'b0;
    endtask

    task automatic finish_and_wait();
        finish = 1'b1;
        next_cycle();
        finish = 1'b0;
        while (!valid) begin
            next_cycle();
        end
        repeat (2) next_cycle();   // Result held for a while
    endtask

    task automatic pulse_clear();
        clear = 1'b1;
        next_cycle();
        clear = 1'b0;
        clear_check: assert (!valid) else
            abort_run($sformatf("FAILED: valid_o = 0x%0h, expected 0x0", valid));
    endtask

    // Inputs and ready are stable at the falling edge
    always @(negedge clk) begin : model_and_check
        if (!rst_n) begin
            model_sum  = '0;
            valid_seen = 1'b0;
        end else begin
            if (valid && !valid_seen) begin
                result_check: assert (acc == model_sum) results_seen++; else
                    abort_run($sformatf("FAILED: acc_o = 0x%08h, expected 0x%08h",
                                        acc, model_sum));
            end
            valid_seen = valid;
            if (clear) begin
                model_sum = '0;
            end else if (ready) begin
                if (valid && (add_valid || mul_valid)) begin
                    model_sum = '0;   // New run after a held result
                end
                if (add_valid) begin
                    model_sum = model_sum + acc_t'(add_data);
                end
                if (mul_valid) begin
                    model_sum = model_sum * acc_t'(mul_data);
                end
            end else if (add_valid || mul_valid) begin
                held_off++;
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycle_cnt++;
        if (dut_i.sva_i.fail_cnt != 0) begin
            abort_run("A protocol assertion in sfm_acc_sva failed");
        end else if (cycle_cnt >= MAX_CYCLES) begin
            abort_run($sformatf("Run timed out after %0d cycles", cycle_cnt));
        end
    end

    initial begin : stimulus
        seed         = 32'h64f;
        rst_n        = 1'b0;
        clear        = 1'b0;
        add_valid    = 1'b0;
        add_data     = '0;
        mul_valid    = 1'b0;
        mul_data     = '0;
        finish       = 1'b0;
        results_seen = 0;
        held_off     = 0;
        cycle_cnt    = 0;
        repeat (3) @(posedge clk);
        #(DRIVE_DLY);
        rst_n = 1'b1;
        next_cycle();

        // Addends only
        drive_random(16, 100, 0);
        drive_random(8, 50, 0);
        finish_and_wait();

        // Mixed traffic, then more queued factors than pipeline slots
        drive_random(1, 100, 0);
        drive_random(30, 60, 40);
        drive_random(6, 0, 100);
        drive_random(5, 100, 50);
        finish_and_wait();

        held_off = 0;
        drive_random(30, 100, 100);   // Both queues back up
        bp_check: assert (held_off > 0) else
            abort_run("ready_o never dropped during the input burst");
        finish_and_wait();

        // Restart straight from a held result
        drive_random(1, 100, 0);
        drive_random(8, 80, 30);
        finish_and_wait();

        pulse_clear();
        drive_random(1, 100, 0);
        drive_random(6, 100, 30);
        pulse_clear();                // Abandoned half way
        drive_random(1, 100, 0);
        drive_random(10, 70, 30);
        finish_and_wait();

        repeat (2) next_cycle();
        if (results_seen == NUM_RESULTS && dut_i.sva_i.fail_cnt == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            abort_run($sformatf("Only %0d of %0d results were checked", results_seen,
                                NUM_RESULTS));
        end
    end

endmodule

// File: sfm_acc_top.f
sfm_pkg.sv
sfm_fifo.sv
sfm_mac_pipe.sv
sfm_accumulator.sv
sfm_acc_top.sv
sfm_acc_sva.sv
tb_sfm_acc.sv

// File: Bender.yml
package:
  name: sfm_acc

sources:
  - files:
      - sfm_pkg.sv
      - sfm_fifo.sv
      - sfm_mac_pipe.sv
      - sfm_accumulator.sv
      - sfm_acc_top.sv
  - target: test
    files:
      - sfm_acc_sva.sv
      - tb_sfm_acc.sv
